/* tb/sdet_input.txt */
// taps, then 7 pairs of decision and residual (8-bit two's complement),
// then the gap flag and the expected RESULT word
00000000 1 05 1 00 1 00 1 00 1 00 1 00 1 00 0 00000001
00000001 1 ff 1 00 1 00 1 02 1 00 1 00 1 00 0 00000043
00000001 1 00 1 ff 1 00 1 00 1 00 1 00 1 00 0 00000006
00000001 0 00 0 01 0 00 0 00 0 00 0 00 0 00 0 00000006
00000001 1 ff 1 00 1 00 1 02 1 00 1 00 1 00 1 00000043
00000001 1 00 1 ff 1 00 1 00 1 00 1 00 1 00 1 00000006

/* sdet.f */
verilog/sdet_pkg.sv
verilog/sdet_axil_regs.sv
verilog/sdet_ctrl_fsm.sv
verilog/sdet_sample_counter.sv
verilog/sdet_sample_window.sv
verilog/sliding_detector.sv
verilog/sdet_top.sv
tb/sdet_chk.sv
tb/sdet_tb.sv

/* Bender.yml */
package:
  name: sdet

sources:
  - verilog/sdet_pkg.sv
  - verilog/sdet_axil_regs.sv
  - verilog/sdet_ctrl_fsm.sv
  - verilog/sdet_sample_counter.sv
  - verilog/sdet_sample_window.sv
  - verilog/sliding_detector.sv
  - verilog/sdet_top.sv
  - target: test
    files:
      - tb/sdet_chk.sv
      - tb/sdet_tb.sv

/* tb/sdet_tb.sv */
`timescale 1ns/100ps

module sdet_tb;
    import sdet_pkg::*;

    localparam int WIDTH     = 4;
    localparam int NUM_SMP   = WIDTH + SEQ_LENGTH;
    localparam int NUM_VECS  = 6;
    localparam int LINE_LEN  = 2*NUM_SMP + 3;      // Taps, pairs, gap, expected
    localparam int MAX_CYCLE = 400*NUM_VECS + 100;

    logic        clk;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic        sample_valid;
    sample_t     sample;
    logic        sample_ready;

    logic [31:0] vec_mem [NUM_VECS*LINE_LEN];
    logic        cur_dec [NUM_SMP];
    int          cur_res [NUM_SMP];
    logic [31:0] lcg_state = 32'd42300;
    logic        gap_mode;
    int          errors;
    int          test_errors;
    int          cur_test;
    int          cycles;

    sdet_top #(.WIDTH(WIDTH)) dut (
        .clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .sample_valid(sample_valid), .sample(sample), .sample_ready(sample_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: test %0d stalled, run stopped after %0d cycles", cur_test, cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int next_rand();
        lcg_state = (lcg_state * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
        return int'(lcg_state >> 16);
    endfunction

    // e(i,j) of the scoring rule, sign taken from decision i
    function automatic int inj_err(input logic [31:0] tw, input int i, input int j);
        int tap;
        tap = $signed(tw[8*j +: 8]);
        return cur_dec[i] ? tap : -tap;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] tw);
        int          h [4];
        int          x;
        int          code;
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < WIDTH; i++) begin
            for (int c = 0; c < 4; c++) begin
                h[c] = 0;
            end
            for (int j = 0; j < SEQ_LENGTH; j++) begin
                x = cur_res[i+j];
                h[0] += x*x;
                x = cur_res[i+j+1] + inj_err(tw, i, j+1);
                h[1] += x*x;
                x = cur_res[i+1+j] + inj_err(tw, i+1, j);
                h[2] += x*x;
                x = cur_res[i+j] + inj_err(tw, i+1, j) + inj_err(tw, i, j+1);
                h[3] += x*x;
            end
            code = 0;
            for (int c = 1; c < 4; c++) begin
                if (h[c] < h[code]) begin
                    code = c;
                end
            end
            w[2*i +: 2] = code[1:0];
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic wait_drive_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        int stall;
        wait_drive_slot();
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        check_value("WREADY with AWREADY", 32'(axil_rsp.wready), 32'h1);
        wait_drive_slot();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        check_value("BRESP", 32'(axil_rsp.bresp), 32'h0);    // OKAY
        stall = gap_mode ? next_rand() % 3 : 0;
        repeat (stall) @(negedge clk);
        wait_drive_slot();
        axil_req.bready = 1'b1;
        wait_drive_slot();
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        int stall;
        wait_drive_slot();
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        wait_drive_slot();
        axil_req.arvalid = 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data  = axil_rsp.rdata;
        check_value("RRESP", 32'(axil_rsp.rresp), 32'h0);    // OKAY
        stall = gap_mode ? next_rand() % 3 : 0;
        repeat (stall) @(negedge clk);
        wait_drive_slot();
        axil_req.rready = 1'b1;
        wait_drive_slot();
        axil_req.rready = 1'b0;
    endtask

    // Back to back beats unless the line asks for source gaps
    task automatic send_window(input int base);
        logic [31:0] rd;
        int          gap;
        wait_drive_slot();
        for (int k = 0; k < NUM_SMP; k++) begin
            if (k == NUM_SMP - 1) begin
                sample_valid = 1'b0;
                axil_read(ADDR_STATUS, rd);     // Not done before the final beat
                check_value("STATUS before last beat", rd, 32'h2);
            end
            gap = gap_mode ? next_rand() % 3 : 0;
            if (gap > 0) begin
                sample_valid = 1'b0;
                repeat (gap) @(posedge clk);
                #10;
            end
            sample_valid     = 1'b1;
            sample.decision  = vec_mem[base+1+2*k][0];
            sample.residual  = vec_mem[base+2+2*k][7:0];
            @(negedge clk);
            while (!sample_ready) @(negedge clk);
            wait_drive_slot();                  // Beat taken on this edge
        end
        sample_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] model;
        int          base;
        axil_req = '0;
        sample_valid = 1'b0;
        sample = '0;
        rst_n = 1'b0;
        gap_mode = 1'b0;
        errors = 0;
        cycles = 0;
        cur_test = 0;
        $readmemh("tb/sdet_input.txt", vec_mem);
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;

        test_errors = 0;
        axil_read(ADDR_STATUS, rd);
        check_value("STATUS after reset", rd, 32'h0);
        axil_read(ADDR_RESULT, rd);
        check_value("RESULT after reset", rd, 32'h0);
        axil_read(ADDR_TAPS, rd);
        check_value("TAPS after reset", rd, 32'h0);
        @(negedge clk);
        check_value("sample_ready after reset", 32'(sample_ready), 32'h0);
        axil_write(ADDR_TAPS, 32'h7f80_01fe);
        axil_read(ADDR_TAPS, rd);
        check_value("TAPS readback", rd, 32'h7f80_01fe);
        $display("test 0 (reset and taps): %s", test_errors == 0 ? "ok" : "FAIL");

        for (int t = 0; t < NUM_VECS; t++) begin
            cur_test = t + 1;
            test_errors = 0;
            base = t * LINE_LEN;
            for (int k = 0; k < NUM_SMP; k++) begin
                cur_dec[k] = vec_mem[base+1+2*k][0];
                cur_res[k] = $signed(vec_mem[base+2+2*k][7:0]);
            end
            gap_mode = vec_mem[base+LINE_LEN-2][0];
            model = ref_word(vec_mem[base]);
            check_value("vector file expected word", vec_mem[base+LINE_LEN-1], model);
            axil_write(ADDR_TAPS, vec_mem[base]);
            axil_read(ADDR_TAPS, rd);
            check_value("TAPS readback", rd, vec_mem[base]);
            axil_write(ADDR_CTRL, 32'h1);
            axil_read(ADDR_STATUS, rd);         // Start clears a previous done
            check_value("STATUS after start", rd, 32'h2);
            send_window(base);
            rd = '0;
            while (!rd[0]) axil_read(ADDR_STATUS, rd);
            check_value("STATUS at done", rd, 32'h1);
            axil_read(ADDR_RESULT, rd);
            check_value("RESULT", rd, model);
            $display("test %0d (gaps %0d): %s", cur_test, gap_mode,
                     test_errors == 0 ? "ok" : "FAIL");
        end

        $display("Totals: %0d tests, %0d errors, %0d assertion failures",
                 NUM_VECS + 1, errors, dut.u_chk.fail_count);
        if (errors == 0 && dut.u_chk.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : sdet_tb

/* tb/sdet_chk.sv */
`timescale 1ns/100ps

module sdet_chk import sdet_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input logic      sample_ready,
    input logic      busy,
    input logic      done
);

    int fail_count = 0;     // Failed assertion attempts

    // Responses stay up until the master takes them
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            fail_count++;
        end

    ready_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !sample_ready)
        else begin
            $error("sample_ready high while idle");
            fail_count++;
        end

    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && busy))
        else begin
            $error("done and busy high together");
            fail_count++;
        end

endmodule : sdet_chk

bind sdet_top sdet_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .sample_ready (sample_ready),
    .busy         (busy),
    .done         (u_regs.done_q)
);

/* verilog/sdet_top.sv */
`timescale 1ns/100ps

module sdet_top import sdet_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    input  logic      sample_valid,
    input  sample_t   sample,
    output logic      sample_ready
);

    logic               start;
    logic               clear;
    logic               capture;
    logic               busy;
    logic               last;
    logic               beat;
    logic [2*WIDTH-1:0] codes;
    reg_word_u          taps;
    sample_t            window [WIDTH+SEQ_LENGTH];

    assign beat = sample_valid & sample_ready;  // Stream handshake

    sdet_axil_regs #(.WIDTH(WIDTH)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .capture  (capture),
        .codes    (codes),
        .busy     (busy),
        .start    (start),
        .taps     (taps)
    );

    sdet_ctrl_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .last         (last),
        .sample_ready (sample_ready),
        .clear        (clear),
        .capture      (capture),
        .busy         (busy)
    );

    sdet_sample_counter #(.WIDTH(WIDTH)) u_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .enable (beat),
        .last   (last)
    );

    sdet_sample_window #(.WIDTH(WIDTH)) u_window (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (beat),
        .sample (sample),
        .window (window)
    );

    sliding_detector #(.WIDTH(WIDTH)) u_detector (
        .window (window),
        .taps   (taps),
        .codes  (codes)
    );

endmodule : sdet_top

/* verilog/sliding_detector.sv */
`timescale 1ns/100ps

module sliding_detector import sdet_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  sample_t            window [WIDTH+SEQ_LENGTH],
    input  reg_word_u          taps,
    output logic [2*WIDTH-1:0] codes
);

    localparam int NUM_SAMPLES = WIDTH + SEQ_LENGTH;
    localparam int TERM_BITS   = ERR_BITS + 2;     // Residual plus two taps

    logic signed [TERM_BITS-1:0] tap_ext [NUM_TAPS];
    logic signed [TERM_BITS-1:0] resid   [NUM_SAMPLES];
    logic signed [TERM_BITS-1:0] inj     [WIDTH+1][NUM_TAPS];  // e(i,j)
    logic        [SUM_BITS-1:0]  sums    [WIDTH][4];

    function automatic logic [SUM_BITS-1:0] square(input logic signed [TERM_BITS-1:0] x);
        logic signed [SUM_BITS-1:0] wide;
        wide = x;
        return wide * wide;
    endfunction

    // Polarity of the injected vector follows the decision bit
    always_comb begin
        for (int j = 0; j < NUM_TAPS; j++) begin
            tap_ext[j] = $signed(taps.taps[j]);
        end
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            resid[k] = $signed(window[k].residual);
        end
        for (int i = 0; i <= WIDTH; i++) begin
            for (int j = 0; j < NUM_TAPS; j++) begin
                inj[i][j] = window[i].decision ? tap_ext[j] : -tap_ext[j];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            for (int h = 0; h < 4; h++) begin
                sums[i][h] = '0;
            end
            for (int j = 0; j < SEQ_LENGTH; j++) begin
                sums[i][0] += square(resid[i+j]);                    // No error
                sums[i][1] += square(resid[i+j+1] + inj[i][j+1]);
                sums[i][2] += square(resid[i+1+j] + inj[i+1][j]);
                sums[i][3] += square(resid[i+j] + inj[i+1][j] + inj[i][j+1]);
            end
        end
    end

    // Strict less-than keeps the lower code on a tie
    always_comb begin
        logic [SUM_BITS-1:0] best;
        logic [1:0]          code;
        for (int i = 0; i < WIDTH; i++) begin
            best = sums[i][0];
            code = 2'd0;
            for (int h = 1; h < 4; h++) begin
                if (sums[i][h] < best) begin
                    best = sums[i][h];
                    code = 2'(h);
                end
            end
            codes[2*i +: 2] = code;
        end
    end

endmodule : sliding_detector

/* verilog/sdet_sample_window.sv */
`timescale 1ns/100ps

module sdet_sample_window import sdet_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  sample_t sample,
    output sample_t window [WIDTH+SEQ_LENGTH]
);

    localparam int NUM_SAMPLES = WIDTH + SEQ_LENGTH;

    sample_t shift_q [NUM_SAMPLES];

    // New beats enter at the top and move toward index 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_SAMPLES; k++) begin
                shift_q[k] <= '0;
            end
        end else if (enable) begin
            for (int k = 0; k < NUM_SAMPLES - 1; k++) begin
                shift_q[k] <= shift_q[k+1];
            end
            shift_q[NUM_SAMPLES-1] <= sample;
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            window[k] = shift_q[k];
        end
    end

endmodule : sdet_sample_window

/* verilog/sdet_sample_counter.sv */
`timescale 1ns/100ps

module sdet_sample_counter import sdet_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic enable,
    output logic last
);

    localparam int NUM_SAMPLES = WIDTH + SEQ_LENGTH;
    localparam int CNT_BITS    = $clog2(NUM_SAMPLES + 1);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            count <= '0;
        end else if (enable && !last) begin
            count <= count + 1'b1;
        end
    end

    assign last = enable && (count == CNT_BITS'(NUM_SAMPLES - 1));

endmodule : sdet_sample_counter

/* verilog/sdet_ctrl_fsm.sv */
`timescale 1ns/100ps

module sdet_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last,
    output logic sample_ready,
    output logic clear,
    output logic capture,
    output logic busy
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        EVAL,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (start) state_next = LOAD;
            LOAD: if (last) state_next = EVAL;   // Final beat of the window
            EVAL: state_next = DONE;
            DONE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Counter restarts on the way into LOAD
    assign clear = (state == IDLE) && start;

    assign sample_ready = (state == LOAD);
    assign capture      = (state == EVAL);   // Window complete, codes settled
    assign busy         = (state == LOAD) || (state == EVAL);

endmodule : sdet_ctrl_fsm

/* verilog/sdet_axil_regs.sv */
`timescale 1ns/100ps

module sdet_axil_regs import sdet_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp,
    input  logic               capture,
    input  logic [2*WIDTH-1:0] codes,
    input  logic               busy,
    output logic               start,
    output reg_word_u          taps
);

    reg_word_u                 wword;
    reg_word_u                 taps_q;
    logic [2*WIDTH-1:0]        result_q;
    logic                      done_q;
    logic                      wr_fire;
    logic                      rd_fire;
    logic                      bvalid_q;
    logic                      rvalid_q;
    logic [AXIL_DATA_BITS-1:0] rdata_q;
    logic [AXIL_DATA_BITS-1:0] rd_word;

    assign wword = axil_req.wdata;

    // Address and data are taken in the same cycle, one at a time
    assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
    assign rd_fire = axil_req.arvalid & ~rvalid_q;

    assign start = wr_fire && (axil_req.awaddr == ADDR_CTRL) && wword.ctrl.start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // Byte-wise tap update under the write strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taps_q <= '0;
        end else if (wr_fire && axil_req.awaddr == ADDR_TAPS) begin
            for (int b = 0; b < NUM_TAPS; b++) begin
                if (axil_req.wstrb[b]) taps_q.taps[b] <= wword.taps[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
            done_q   <= 1'b0;
        end else if (capture) begin
            result_q <= codes;
            done_q   <= 1'b1;
        end else if (start && !busy) begin
            done_q   <= 1'b0;       // New run pending
        end
    end

    always_comb begin
        case (axil_req.araddr)
            ADDR_TAPS:   rd_word = taps_q;
            ADDR_STATUS: rd_word = {30'b0, busy, done_q};
            ADDR_RESULT: rd_word = AXIL_DATA_BITS'(result_q);
            default:     rd_word = '0;     // CTRL is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rdata_q  <= rd_word;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = RESP_OKAY;
    assign axil_rsp.arready = rd_fire;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = RESP_OKAY;

    assign taps = taps_q;

endmodule : sdet_axil_regs

/* verilog/sdet_pkg.sv */
package sdet_pkg;

    localparam int SEQ_LENGTH = 3;              // Injected error length
    localparam int NUM_TAPS   = SEQ_LENGTH + 1;
    localparam int ERR_BITS   = 8;              // Residual and tap width
    localparam int SUM_BITS   = 22;             // One hypothesis sum

    localparam int AXIL_ADDR_BITS = 32;
    localparam int AXIL_DATA_BITS = 32;

    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_TAPS   = 32'h0;
    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_CTRL   = 32'h4;
    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_STATUS = 32'h8;
    localparam logic [AXIL_ADDR_BITS-1:0] ADDR_RESULT = 32'hC;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // One stream beat, hard decision plus residual error
    typedef struct packed {
        logic                       decision;
        logic signed [ERR_BITS-1:0] residual;
    } sample_t;

    typedef struct packed {
        logic                        awvalid;
        logic [AXIL_ADDR_BITS-1:0]   awaddr;
        logic                        wvalid;
        logic [AXIL_DATA_BITS-1:0]   wdata;
        logic [AXIL_DATA_BITS/8-1:0] wstrb;
        logic                        bready;
        logic                        arvalid;
        logic [AXIL_ADDR_BITS-1:0]   araddr;
        logic                        rready;
    } axil_req_t;

    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic                      bvalid;
        logic [1:0]                bresp;
        logic                      arready;
        logic                      rvalid;
        logic [AXIL_DATA_BITS-1:0] rdata;
        logic [1:0]                rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [30:0] reserved;
        logic        start;
    } ctrl_word_t;

    // Write word seen either as the tap set or as a command
    typedef union packed {
        logic [NUM_TAPS-1:0][ERR_BITS-1:0] taps;    // Tap 0 in the low byte
        ctrl_word_t                        ctrl;
    } reg_word_u;

endpackage : sdet_pkg
